//--- all.f
design/fetch_pkg.sv
design/ibus_pkg.sv
design/fetch_fifo.sv
design/prefetch_buffer.sv
design/if_stage.sv
verif/imem_model.sv
verif/fetch_tb.sv

//--- design/fetch_fifo.sv
//////////////////////////////////////////////////
// circular buffer of fetched words, FifoDepth >= 2
// push while full is not guarded, caller budgets room
// flush wins over a push in the same cycle
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo #(
  parameter int FifoDepth = 2
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           flush_i,
  input  wire logic                           push_i,
  input  wire fetch_pkg::fetch_entry_t        entry_i,
  input  wire logic                           pop_i,
  output logic                                valid_o,
  output fetch_pkg::fetch_entry_t             entry_o,
  output logic [$clog2(FifoDepth+1)-1:0]      level_o
);

  localparam int PtrW = $clog2(FifoDepth);
  localparam int LvlW = $clog2(FifoDepth+1);

  fetch_pkg::fetch_entry_t mem_q [FifoDepth];  // payload only

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_inc, rd_ptr_inc;
  logic [LvlW-1:0] cnt_q;
  logic            do_push, do_pop;

  // pointers wrap by hand, depth need not be a power of two
  assign wr_ptr_inc = (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
  assign rd_ptr_inc = (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;

  assign do_push = push_i & ~flush_i;
  assign do_pop  = pop_i & (cnt_q != '0) & ~flush_i;  // popping empty is ignored

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;  // drop everything in one cycle
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_inc;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_inc;
      end
      cnt_q <= cnt_q + LvlW'(do_push) - LvlW'(do_pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  assign valid_o = (cnt_q != '0);
  assign entry_o = mem_q[rd_ptr_q];  // head, first-word fall-through
  assign level_o = cnt_q;

endmodule

`default_nettype wire

//--- design/fetch_pkg.sv
//////////////////////////////////////////////////
// fetch stage types: pc mux selects, cause, IF-ID word
// boot address is assumed 256-byte aligned by the user
//////////////////////////////////////////////////
`default_nettype none

package fetch_pkg;

  // next-pc source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,  // return from trap, mepc
    PC_DRET = 3'd4   // return from debug, depc
  } pc_sel_e;

  // exception target select
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,  // debug halt request
    EXC_PC_DBG_EXC = 2'd3   // exception while in debug mode
  } exc_pc_sel_e;

  typedef struct packed {
    logic       irq;  // set for interrupts
    logic [5:0] id;   // vector index
  } exc_cause_t;

  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_sel;
    exc_cause_t  exc_cause;
  } fetch_ctrl_t;

  typedef struct packed {
    logic [31:0] mepc;
    logic [31:0] depc;
    logic [31:0] mtvec;  // low byte ignored
  } csr_pcs_t;

  // fetched word on its way to ID
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
  } fetch_entry_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] pc;
    logic        fetch_err;
    logic        is_compressed;
  } id_instr_t;

endpackage

`default_nettype wire

//--- design/ibus_pkg.sv
//////////////////////////////////////////////////
// instruction bus: req/gnt handshake, in-order rvalid
// one response per granted request, word aligned only
//////////////////////////////////////////////////
`default_nettype none

package ibus_pkg;

  // master to slave
  typedef struct packed {
    logic        req;
    logic [31:0] addr;  // held while req waits for gnt
  } ibus_req_t;

  // slave to master
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;     // bus error, travels with the word
  } ibus_rsp_t;

endpackage

`default_nettype wire

//--- design/if_stage.sv
//////////////////////////////////////////////////
// fetch stage top: next-pc select, prefetch, IF-ID reg
// boot_addr_i must be 256-byte aligned, low byte is ignored
// compressed words are flagged only, never realigned
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module if_stage #(
  parameter logic [31:0] DmHaltAddr      = 32'h1a11_0800,
  parameter logic [31:0] DmExceptionAddr = 32'h1a11_0808,
  parameter int          FifoDepth       = 2
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic [31:0]            boot_addr_i,
  input  wire logic                   req_i,          // fetch enable level
  input  wire fetch_pkg::fetch_ctrl_t ctrl_i,
  input  wire fetch_pkg::csr_pcs_t    csr_i,
  input  wire logic [31:0]            branch_target_i,
  input  wire logic                   id_ready_i,
  input  wire logic                   valid_clear_i,
  input  wire ibus_pkg::ibus_rsp_t    ibus_rsp_i,
  output ibus_pkg::ibus_req_t         ibus_req_o,
  output fetch_pkg::id_instr_t        id_o,
  output logic                        id_valid_o,
  output logic                        id_new_o,       // one cycle per arriving instr
  output logic [31:0]                 pc_if_o,
  output logic                        mtvec_init_o,
  output logic                        busy_o
);

  logic [31:0]             exc_pc;
  logic [31:0]             next_pc;
  logic                    fetch_valid;
  logic                    accept;
  logic                    valid_q, new_q;
  fetch_pkg::fetch_entry_t fetch_entry;
  fetch_pkg::id_instr_t    id_d, id_q;

  //////////////////////////////////////////////////
  // pc muxes
  //////////////////////////////////////////////////
  always_comb begin
    unique case (ctrl_i.exc_sel)
      fetch_pkg::EXC_PC_EXC:     exc_pc = {csr_i.mtvec[31:8], 8'h00};
      fetch_pkg::EXC_PC_IRQ:     exc_pc = {csr_i.mtvec[31:8], ctrl_i.exc_cause.id, 2'b00};
      fetch_pkg::EXC_PC_DBD:     exc_pc = DmHaltAddr;
      fetch_pkg::EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:                   exc_pc = {csr_i.mtvec[31:8], 8'h00};
    endcase
  end

  always_comb begin
    unique case (ctrl_i.pc_sel)
      fetch_pkg::PC_BOOT: next_pc = {boot_addr_i[31:8], 8'h00};
      fetch_pkg::PC_JUMP: next_pc = branch_target_i;
      fetch_pkg::PC_EXC:  next_pc = exc_pc;     // trap or debug entry
      fetch_pkg::PC_ERET: next_pc = csr_i.mepc;
      fetch_pkg::PC_DRET: next_pc = csr_i.depc;
      default:            next_pc = {boot_addr_i[31:8], 8'h00};
    endcase
  end

  // csr file loads mtvec from boot address
  assign mtvec_init_o = ctrl_i.pc_set & (ctrl_i.pc_sel == fetch_pkg::PC_BOOT);

  prefetch_buffer #(
    .FifoDepth (FifoDepth)
  ) i_prefetch (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .branch_i   (ctrl_i.pc_set),
    .addr_i     ({next_pc[31:2], 2'b00}),  // fetch is word aligned
    .ready_i    (id_ready_i),
    .ibus_rsp_i (ibus_rsp_i),
    .valid_o    (fetch_valid),
    .entry_o    (fetch_entry),
    .ibus_req_o (ibus_req_o),
    .busy_o     (busy_o)
  );

  assign pc_if_o = fetch_entry.addr;

  //////////////////////////////////////////////////
  // IF-ID register
  //////////////////////////////////////////////////
  // a redirect squashes both the head entry and the held instr
  assign accept = fetch_valid & id_ready_i & ~ctrl_i.pc_set;

  assign id_d.rdata         = fetch_entry.rdata;
  assign id_d.pc            = fetch_entry.addr;
  assign id_d.fetch_err     = fetch_entry.err;
  assign id_d.is_compressed = (fetch_entry.rdata[1:0] != 2'b11);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= accept | (valid_q & ~valid_clear_i & ~ctrl_i.pc_set);
      new_q   <= accept;  // pulse, one per loaded instr
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (accept) begin
      id_q <= id_d;  // frozen while ID stalls
    end
  end

  assign id_o       = id_q;
  assign id_valid_o = valid_q;
  assign id_new_o   = new_q;

endmodule

`default_nettype wire

//--- design/prefetch_buffer.sv
//////////////////////////////////////////////////
// word-aligned prefetcher on the req/gnt/rvalid bus
// stale responses after a branch are dropped by count
// an ungranted request is held across a branch, then discarded
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer #(
  parameter int FifoDepth = 2
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     req_i,
  input  wire logic                     branch_i,
  input  wire logic [31:0]              addr_i,    // word aligned
  input  wire logic                     ready_i,
  input  wire ibus_pkg::ibus_rsp_t      ibus_rsp_i,
  output logic                          valid_o,
  output fetch_pkg::fetch_entry_t       entry_o,
  output ibus_pkg::ibus_req_t           ibus_req_o,
  output logic                          busy_o
);

  localparam int LvlW = $clog2(FifoDepth+1);

  logic [31:0]     fetch_addr_q;   // next new request
  logic [31:0]     rsp_addr_q;     // address of next kept response
  logic [31:0]     stale_addr_q;   // old-path request still waiting for gnt
  logic            wait_q, stale_q;
  logic [LvlW-1:0] outst_q, outst_d;
  logic [LvlW-1:0] discard_q, discard_d;
  logic [LvlW-1:0] fifo_level;
  logic [LvlW:0]   budget;
  logic            room, new_req, gnt_ok, rsp_drop, push;
  fetch_pkg::fetch_entry_t push_entry;

  // stored plus outstanding must stay below depth to issue
  assign budget  = (LvlW+1)'(fifo_level) + (LvlW+1)'(outst_q);
  assign room    = budget < (LvlW+1)'(FifoDepth);
  assign new_req = req_i & room & ~branch_i;  // target goes out next cycle

  assign ibus_req_o.req  = wait_q | new_req;  // a waiting request is never retracted
  assign ibus_req_o.addr = stale_q ? stale_addr_q : fetch_addr_q;

  assign gnt_ok   = ibus_req_o.req & ibus_rsp_i.gnt;
  assign rsp_drop = (discard_q != '0);
  assign push     = ibus_rsp_i.rvalid & ~rsp_drop & ~branch_i;

  assign outst_d = outst_q + LvlW'(gnt_ok) - LvlW'(ibus_rsp_i.rvalid);

  always_comb begin
    if (branch_i) begin
      discard_d = outst_d;  // all still in flight after this edge are old path
    end else begin
      discard_d = discard_q
                  - LvlW'(ibus_rsp_i.rvalid & rsp_drop)
                  + LvlW'(gnt_ok & stale_q);  // held old request finally granted
    end
  end

  //////////////////////////////////////////////////
  // bus bookkeeping
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
      rsp_addr_q   <= '0;
      wait_q       <= 1'b0;
      stale_q      <= 1'b0;
      outst_q      <= '0;
      discard_q    <= '0;
    end else begin
      wait_q    <= ibus_req_o.req & ~ibus_rsp_i.gnt;
      stale_q   <= ibus_req_o.req & ~ibus_rsp_i.gnt & (stale_q | branch_i);
      outst_q   <= outst_d;
      discard_q <= discard_d;
      if (branch_i) begin
        fetch_addr_q <= addr_i;
        rsp_addr_q   <= addr_i;
      end else begin
        if (gnt_ok & ~stale_q) begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        if (push) begin
          rsp_addr_q <= rsp_addr_q + 32'd4;
        end
      end
    end
  end

  // address of whatever sits on the bus, kept if it turns stale
  always_ff @(posedge clk_i) begin
    stale_addr_q <= ibus_req_o.addr;
  end

  assign push_entry.rdata = ibus_rsp_i.rdata;
  assign push_entry.addr  = rsp_addr_q;
  assign push_entry.err   = ibus_rsp_i.err;

  fetch_fifo #(
    .FifoDepth (FifoDepth)
  ) i_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (branch_i),
    .push_i  (push),
    .entry_i (push_entry),
    .pop_i   (valid_o & ready_i),
    .valid_o (valid_o),
    .entry_o (entry_o),
    .level_o (fifo_level)
  );

  assign busy_o = wait_q | (outst_q != '0);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# compile and run the fetch testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fetch_tb -f all.f --Mdir obj_dir -o fetch_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/fetch_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0

//--- verif/fetch_tb.sv
//////////////////////////////////////////////////
// fetch stage testbench, random redirects and stalls
// ends after NumInstr checked instructions
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam logic [31:0] BootAddr      = 32'h0000_0e00;  // reaches err region at 0xf00
  localparam logic [31:0] HaltAddr      = 32'h1a11_0f00;
  localparam logic [31:0] DbgExcAddr    = 32'h1a11_0c08;
  localparam int          NumInstr      = 400;
  localparam int          TimeoutCycles = NumInstr * 7 + 200;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_i = 1'b0, id_ready_i = 1'b0, valid_clear_i = 1'b0;
  logic [31:0] boot_addr_i = '0, branch_target_i = '0;
  fetch_pkg::fetch_ctrl_t ctrl = '0;
  fetch_pkg::csr_pcs_t    csr = '0;
  ibus_pkg::ibus_req_t    ibus_req;
  ibus_pkg::ibus_rsp_t    ibus_rsp;
  fetch_pkg::id_instr_t   id, prev_id, exp_id;
  logic id_valid, id_new, mtvec_init, busy;
  logic [31:0] pc_if;

  integer      seed = 32'h7aa2;
  int          cycles = 0, n_instr = 0;
  logic [31:0] exp_pc, rnd, prev_pc_if;
  logic        prev_valid, prev_clear, prev_pc_set, prev_ready, after_redirect;
  logic        boot_sel;

  always #4 clk_i = ~clk_i;  // 8 ns period

  if_stage #(
    .DmHaltAddr      (HaltAddr),
    .DmExceptionAddr (DbgExcAddr),
    .FifoDepth       (3)
  ) i_dut (
    .clk_i (clk_i), .rst_ni (rst_ni), .boot_addr_i (boot_addr_i), .req_i (req_i),
    .ctrl_i (ctrl), .csr_i (csr), .branch_target_i (branch_target_i),
    .id_ready_i (id_ready_i), .valid_clear_i (valid_clear_i), .ibus_rsp_i (ibus_rsp),
    .ibus_req_o (ibus_req), .id_o (id), .id_valid_o (id_valid), .id_new_o (id_new),
    .pc_if_o (pc_if), .mtvec_init_o (mtvec_init), .busy_o (busy)
  );

  imem_model #(.Seed (32'h7aa2)) i_imem (
    .clk_i (clk_i), .rst_ni (rst_ni), .ibus_req_i (ibus_req), .ibus_rsp_o (ibus_rsp)
  );

  //////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////
  function automatic logic [31:0] redirect_target(fetch_pkg::fetch_ctrl_t c,
                                                  fetch_pkg::csr_pcs_t s,
                                                  logic [31:0] boot, logic [31:0] jump);
    logic [31:0] t;
    logic [31:0] vec_base;
    vec_base = s.mtvec & 32'hffff_ff00;
    case (c.pc_sel)
      fetch_pkg::PC_JUMP: t = jump;
      fetch_pkg::PC_ERET: t = s.mepc;
      fetch_pkg::PC_DRET: t = s.depc;
      fetch_pkg::PC_EXC: begin
        case (c.exc_sel)
          fetch_pkg::EXC_PC_IRQ:     t = vec_base + {24'h0, c.exc_cause.id, 2'b00};
          fetch_pkg::EXC_PC_DBD:     t = HaltAddr;
          fetch_pkg::EXC_PC_DBG_EXC: t = DbgExcAddr;
          default:                   t = vec_base;
        endcase
      end
      default: t = boot & 32'hffff_ff00;  // boot base
    endcase
    return t & 32'hffff_fffc;  // fetch is word aligned
  endfunction

  task automatic check_instr(string name, fetch_pkg::id_instr_t exp, fetch_pkg::id_instr_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_addr(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: %0d of %0d instructions after %0d cycles", n_instr, NumInstr, cycles);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////
  // stimulus and checks, once per falling edge
  //////////////////////////////////////////////////
  initial begin
    {prev_id, prev_valid, prev_clear, prev_pc_set, prev_ready} = '0;
    exp_pc = '0;
    prev_pc_if = '0;
    after_redirect = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    // reset values
    check_bit("reset req", 1'b0, ibus_req.req);
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset valid", 1'b0, id_valid);
    check_instr("reset id", '0, id);
    while (n_instr < NumInstr) begin
      if (id_new) begin
        exp_id.pc            = exp_pc;
        exp_id.rdata         = exp_pc ^ 32'h5a5a_0013;  // memory function
        exp_id.fetch_err     = (exp_pc[11:8] == 4'hf);
        exp_id.is_compressed = (exp_id.rdata[1:0] != 2'b11);
        if (after_redirect) begin
          check_addr("redirect target", exp_pc, id.pc);
        end
        check_addr("pc_if", exp_pc, prev_pc_if);  // head address in the accept cycle
        check_instr("fetch", exp_id, id);
        check_bit("valid with new", 1'b1, id_valid);
        exp_pc         = exp_pc + 32'd4;
        after_redirect = 1'b0;
        n_instr        = n_instr + 1;
      end else begin
        check_instr("id hold", prev_id, id);  // frozen without a load
        check_bit("valid keep", prev_valid & ~prev_clear & ~prev_pc_set, id_valid);
      end
      if (!prev_ready) check_bit("stall no new", 1'b0, id_new);
      if (prev_pc_set) check_bit("squash no new", 1'b0, id_new);
      prev_id    = id;
      prev_valid = id_valid;
      prev_pc_if = pc_if;
      // new inputs
      rnd             = $random(seed);
      branch_target_i = $random(seed);
      csr.mepc        = $random(seed);
      csr.depc        = $random(seed);
      csr.mtvec       = $random(seed);
      boot_addr_i     = BootAddr | {24'h0, rnd[31:24]};  // low byte ignored
      boot_sel        = !req_i || (rnd[2:0] % 3'd5 == 3'd0);  // boot source chosen
      ctrl.pc_set     = (rnd[15:12] == 4'h0) || !req_i;   // first pass is the boot
      ctrl.pc_sel     = boot_sel ? fetch_pkg::PC_BOOT : fetch_pkg::pc_sel_e'(rnd[2:0] % 3'd5);
      ctrl.exc_sel    = fetch_pkg::exc_pc_sel_e'(rnd[4:3]);
      ctrl.exc_cause  = {rnd[11], rnd[10:5]};
      id_ready_i      = (rnd[17:16] != 2'b00);
      valid_clear_i   = (rnd[20:18] == 3'd0);
      req_i           = 1'b1;
      if (ctrl.pc_set) begin
        exp_pc         = redirect_target(ctrl, csr, boot_addr_i, branch_target_i);
        after_redirect = 1'b1;
      end
      prev_clear  = valid_clear_i;
      prev_pc_set = ctrl.pc_set;
      prev_ready  = id_ready_i;
      #1;
      check_bit("mtvec_init", ctrl.pc_set & boot_sel, mtvec_init);
      @(negedge clk_i);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/imem_model.sv
//////////////////////////////////////////////////
// bus slave for the fetch testbench, random gnt
// in-order rvalid 1..3 cycles after gnt, data from address
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module imem_model #(
  parameter logic [31:0] Seed = 32'h7aa2
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire ibus_pkg::ibus_req_t  ibus_req_i,
  output ibus_pkg::ibus_rsp_t       ibus_rsp_o
);

  integer      seed = Seed;
  logic        gnt_en_q;
  logic        rvalid_q, err_q;
  logic [31:0] rdata_q;
  logic [31:0] pend_addr [$];  // granted, not yet answered
  int          pend_due  [$];  // cycle of the answer
  int          cyc, last_due;

  assign ibus_rsp_o.gnt    = ibus_req_i.req & gnt_en_q;  // gnt in the req cycle
  assign ibus_rsp_o.rvalid = rvalid_q;
  assign ibus_rsp_o.rdata  = rdata_q;
  assign ibus_rsp_o.err    = err_q;

  always @(posedge clk_i or negedge rst_ni) begin
    int unsigned r;
    int          due;
    logic [31:0] a;
    if (!rst_ni) begin
      gnt_en_q <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
      err_q    <= 1'b0;
      pend_addr.delete();
      pend_due.delete();
      cyc      = 0;
      last_due = 0;
    end else begin
      r = $random(seed);
      gnt_en_q <= (r[1:0] != 2'b00);  // grant 3 of 4 cycles
      if (ibus_req_i.req && ibus_rsp_o.gnt) begin
        due = cyc + 1 + int'(r[9:2] % 8'd3);
        if (due <= last_due) begin
          due = last_due + 1;  // one rvalid per cycle, order kept
        end
        last_due = due;
        pend_addr.push_back(ibus_req_i.addr);
        pend_due.push_back(due);
      end
      // answer for the cycle that starts now
      if (pend_due.size() != 0 && pend_due[0] <= cyc + 1) begin
        a = pend_addr.pop_front();
        void'(pend_due.pop_front());
        rvalid_q <= 1'b1;
        rdata_q  <= a ^ 32'h5a5a_0013;
        err_q    <= (a[11:8] == 4'hf);
      end else begin
        rvalid_q <= 1'b0;
      end
      cyc = cyc + 1;
    end
  end

endmodule

`default_nettype wire
